// ==== common/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int RAM_AW    = 12;             // only the low address bits reach the RAM.
    localparam int RAM_BYTES = 1 << RAM_AW;

    // the encoded value is the index of the last byte of the access.
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd3
    } accessLen;

endpackage

`default_nettype wire

// ==== common/lsuPkg.sv ====
`default_nettype none

package lsuPkg;

    localparam int TAG_W     = 4;
    localparam int SLB_DEPTH = 4;              // power of two.
    localparam int SLB_PTR_W = $clog2(SLB_DEPTH);

    typedef enum logic [2:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } memOp;

    typedef enum logic [1:0] {
        IDLE, READ, WRITE, FINISH
    } ctrlState;

    function automatic memBusPkg::accessLen opLen(memOp op);
        case (op)
            LB, LBU, SB: return memBusPkg::LEN_BYTE;
            LH, LHU, SH: return memBusPkg::LEN_HALF;
            default:     return memBusPkg::LEN_WORD;
        endcase
    endfunction

    function automatic logic opIsStore(memOp op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

`default_nettype wire

// ==== slb/loadStoreBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreBuffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rdy,
    input  wire                          issueEn,
    input  wire lsuPkg::memOp            issueOp,
    input  wire [memBusPkg::ADDR_W-1:0]  issueAddr,
    input  wire [memBusPkg::DATA_W-1:0]  issueData,
    input  wire [lsuPkg::TAG_W-1:0]      issueTag,
    input  wire                          busy,
    output logic                         full,
    output logic                         portEn,
    output lsuPkg::memOp                 portOp,
    output logic [memBusPkg::ADDR_W-1:0] portAddr,
    output logic [memBusPkg::DATA_W-1:0] portData,
    output logic [lsuPkg::TAG_W-1:0]     portTag
);

    // queue storage, one array per field.
    lsuPkg::memOp                 opQ   [lsuPkg::SLB_DEPTH];
    logic [memBusPkg::ADDR_W-1:0] addrQ [lsuPkg::SLB_DEPTH];
    logic [memBusPkg::DATA_W-1:0] dataQ [lsuPkg::SLB_DEPTH];
    logic [lsuPkg::TAG_W-1:0]     tagQ  [lsuPkg::SLB_DEPTH];

    logic [lsuPkg::SLB_PTR_W-1:0] head;
    logic [lsuPkg::SLB_PTR_W-1:0] tail;
    logic [lsuPkg::SLB_PTR_W:0]   count;
    logic                         accept;
    logic                         launch;

    assign full   = (count == (lsuPkg::SLB_PTR_W + 1)'(lsuPkg::SLB_DEPTH));
    assign accept = issueEn && !full;

    // busy only rises the cycle after our own pulse.
    assign launch = (count != '0) && !busy && !portEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            portEn <= 1'b0;
        end else if (rdy) begin
            portEn <= launch;
            if (accept) begin
                tail <= tail + 1'b1;           // wraps at the depth.
            end
            if (launch) begin
                head <= head + 1'b1;
            end
            if (accept && !launch) begin
                count <= count + 1'b1;
            end else if (launch && !accept) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (accept) begin
                opQ[tail]   <= issueOp;
                addrQ[tail] <= issueAddr;
                dataQ[tail] <= issueData;
                tagQ[tail]  <= issueTag;
            end
            // head fields go out together with the pulse.
            if (launch) begin
                portOp   <= opQ[head];
                portAddr <= addrQ[head];
                portData <= dataQ[head];
                portTag  <= tagQ[head];
            end
        end
    end

endmodule

`default_nettype wire

// ==== dcache/dataPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataPort (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rdy,
    input  wire                          portEn,
    input  wire lsuPkg::memOp            portOp,
    input  wire [memBusPkg::ADDR_W-1:0]  portAddr,
    input  wire [memBusPkg::DATA_W-1:0]  portData,
    input  wire [lsuPkg::TAG_W-1:0]      portTag,
    input  wire                          mcDone,
    input  wire [memBusPkg::DATA_W-1:0]  mcRdata,
    output logic                         busy,
    output logic                         mcEn,
    output lsuPkg::memOp                 mcOp,
    output logic [memBusPkg::ADDR_W-1:0] mcAddr,
    output logic [memBusPkg::DATA_W-1:0] mcWdata,
    output logic                         doneEn,
    output logic [memBusPkg::DATA_W-1:0] doneData,
    output logic [lsuPkg::TAG_W-1:0]     doneTag
);

    logic                     occupied;
    logic [lsuPkg::TAG_W-1:0] tagLatch;        // tag of the request in flight.

    // held high through reset so nothing issues early.
    always_comb begin
        if (rst) begin
            busy = 1'b1;
        end else if (rdy) begin
            busy = occupied;
        end else begin
            busy = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            mcEn     <= 1'b0;
            doneEn   <= 1'b0;
        end else if (rdy) begin
            doneEn <= mcDone;
            mcEn   <= portEn;
            if (portEn) begin
                occupied <= 1'b1;
            end else if (mcDone) begin
                occupied <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (portEn) begin
                mcOp     <= portOp;
                mcAddr   <= portAddr;
                mcWdata  <= portData;
                tagLatch <= portTag;
            end
            if (mcDone) begin
                doneData <= mcRdata;
                doneTag  <= tagLatch;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/memCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rdy,
    input  wire                          mcEn,
    input  wire lsuPkg::memOp            mcOp,
    input  wire [memBusPkg::ADDR_W-1:0]  mcAddr,
    input  wire [memBusPkg::DATA_W-1:0]  mcWdata,
    input  wire [memBusPkg::BYTE_W-1:0]  ramDout,
    output logic                         mcDone,
    output logic [memBusPkg::DATA_W-1:0] mcRdata,
    output logic [memBusPkg::RAM_AW-1:0] ramAddr,
    output logic                         ramWe,
    output logic [memBusPkg::BYTE_W-1:0] ramDin
);

    lsuPkg::ctrlState             state;
    lsuPkg::memOp                 op;
    logic [1:0]                   idx;         // byte being presented to the RAM.
    logic [1:0]                   lastIdx;
    logic [1:0]                   rdIdx;       // byte returning from the RAM.
    logic                         rdValid;
    logic [memBusPkg::RAM_AW-1:0] base;
    logic [memBusPkg::RAM_AW-1:0] curAddr;
    logic [memBusPkg::RAM_AW-1:0] lastAddr;
    logic [memBusPkg::DATA_W-1:0] wdata;
    logic [memBusPkg::DATA_W-1:0] rdata;
    logic [memBusPkg::DATA_W-1:0] loadWord;

    function automatic logic [memBusPkg::DATA_W-1:0] extendLoad(
        lsuPkg::memOp o,
        logic [memBusPkg::DATA_W-1:0] w
    );
        case (o)
            lsuPkg::LB:  return {{(memBusPkg::DATA_W-8){w[7]}}, w[7:0]};
            lsuPkg::LH:  return {{(memBusPkg::DATA_W-16){w[15]}}, w[15:0]};
            lsuPkg::LBU: return {{(memBusPkg::DATA_W-8){1'b0}}, w[7:0]};
            lsuPkg::LHU: return {{(memBusPkg::DATA_W-16){1'b0}}, w[15:0]};
            lsuPkg::LW:  return w;
            default:     return '0;            // stores report zero.
        endcase
    endfunction

    assign curAddr = base + {{(memBusPkg::RAM_AW-2){1'b0}}, idx};

    // during a pause the RAM keeps seeing the last active address.
    assign ramAddr = rdy ? curAddr : lastAddr;
    assign ramWe   = rdy && (state == lsuPkg::WRITE);
    assign ramDin  = wdata[idx*memBusPkg::BYTE_W +: memBusPkg::BYTE_W];

    // last byte of a load is still on ramDout during FINISH.
    always_comb begin
        loadWord = rdata;
        loadWord[rdIdx*memBusPkg::BYTE_W +: memBusPkg::BYTE_W] = ramDout;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= lsuPkg::IDLE;
            idx     <= '0;
            rdValid <= 1'b0;
            mcDone  <= 1'b0;
        end else if (rdy) begin
            mcDone  <= 1'b0;
            rdValid <= (state == lsuPkg::READ);
            case (state)
                lsuPkg::IDLE: begin
                    if (mcEn) begin
                        idx   <= '0;
                        state <= lsuPkg::opIsStore(mcOp) ? lsuPkg::WRITE : lsuPkg::READ;
                    end
                end
                lsuPkg::READ, lsuPkg::WRITE: begin
                    if (idx == lastIdx) begin
                        state <= lsuPkg::FINISH;
                    end else begin
                        idx <= idx + 2'd1;
                    end
                end
                default: begin
                    mcDone <= 1'b1;
                    state  <= lsuPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            lastAddr <= ramAddr;
            rdIdx    <= idx;
            if (rdValid) begin
                rdata[rdIdx*memBusPkg::BYTE_W +: memBusPkg::BYTE_W] <= ramDout;
            end
            if (state == lsuPkg::IDLE && mcEn) begin
                op      <= mcOp;
                base    <= mcAddr[memBusPkg::RAM_AW-1:0];
                wdata   <= mcWdata;
                lastIdx <= lsuPkg::opLen(mcOp);
            end
            if (state == lsuPkg::FINISH) begin
                mcRdata <= extendLoad(op, loadWord);
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/byteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  wire                          clk,
    input  wire [memBusPkg::RAM_AW-1:0]  ramAddr,
    input  wire                          ramWe,
    input  wire [memBusPkg::BYTE_W-1:0]  ramDin,
    output logic [memBusPkg::BYTE_W-1:0] ramDout
);

    // 4 KiB of byte storage.
    logic [memBusPkg::BYTE_W-1:0] mem [memBusPkg::RAM_BYTES];

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramDin;
        end
        ramDout <= mem[ramAddr];               // old contents on a write cycle.
    end

endmodule

`default_nettype wire

// ==== src/lsuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTop (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rdy,
    input  wire                          issueEn,
    input  wire lsuPkg::memOp            issueOp,
    input  wire [memBusPkg::ADDR_W-1:0]  issueAddr,
    input  wire [memBusPkg::DATA_W-1:0]  issueData,
    input  wire [lsuPkg::TAG_W-1:0]      issueTag,
    output logic                         full,
    output logic                         doneEn,
    output logic [memBusPkg::DATA_W-1:0] doneData,
    output logic [lsuPkg::TAG_W-1:0]     doneTag
);

    // buffer to data port.
    logic                         busy;
    logic                         portEn;
    lsuPkg::memOp                 portOp;
    logic [memBusPkg::ADDR_W-1:0] portAddr;
    logic [memBusPkg::DATA_W-1:0] portData;
    logic [lsuPkg::TAG_W-1:0]     portTag;

    // data port to controller.
    logic                         mcEn;
    lsuPkg::memOp                 mcOp;
    logic [memBusPkg::ADDR_W-1:0] mcAddr;
    logic [memBusPkg::DATA_W-1:0] mcWdata;
    logic                         mcDone;
    logic [memBusPkg::DATA_W-1:0] mcRdata;

    // controller to RAM.
    logic [memBusPkg::RAM_AW-1:0] ramAddr;
    logic                         ramWe;
    logic [memBusPkg::BYTE_W-1:0] ramDin;
    logic [memBusPkg::BYTE_W-1:0] ramDout;

    loadStoreBuffer uSlb (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issueEn(issueEn), .issueOp(issueOp), .issueAddr(issueAddr),
        .issueData(issueData), .issueTag(issueTag),
        .busy(busy), .full(full),
        .portEn(portEn), .portOp(portOp), .portAddr(portAddr),
        .portData(portData), .portTag(portTag)
    );

    dataPort uPort (
        .clk(clk), .rst(rst), .rdy(rdy),
        .portEn(portEn), .portOp(portOp), .portAddr(portAddr),
        .portData(portData), .portTag(portTag),
        .mcDone(mcDone), .mcRdata(mcRdata), .busy(busy),
        .mcEn(mcEn), .mcOp(mcOp), .mcAddr(mcAddr), .mcWdata(mcWdata),
        .doneEn(doneEn), .doneData(doneData), .doneTag(doneTag)
    );

    memCtrl uCtrl (
        .clk(clk), .rst(rst), .rdy(rdy),
        .mcEn(mcEn), .mcOp(mcOp), .mcAddr(mcAddr), .mcWdata(mcWdata),
        .ramDout(ramDout), .mcDone(mcDone), .mcRdata(mcRdata),
        .ramAddr(ramAddr), .ramWe(ramWe), .ramDin(ramDin)
    );

    byteRam uRam (
        .clk(clk), .ramAddr(ramAddr), .ramWe(ramWe),
        .ramDin(ramDin), .ramDout(ramDout)
    );

endmodule

`default_nettype wire

// ==== bench/lsuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTb;

    localparam int CLK_PERIOD = 100;
    localparam int OP_CYCLES  = 16;            // worst single access, issue to port release.
    localparam int PAUSE_MAX  = 6;
    localparam int TRAFFIC_N  = 40;
    localparam int FILL_WORDS = 32;
    localparam int MIX_ROUNDS = 20;
    localparam int PLAIN_OPS  = 2 + 15 + FILL_WORDS + 3 * MIX_ROUNDS + TRAFFIC_N;
    localparam int WATCHDOG_CYCLES =
        2 * (5 + PLAIN_OPS * OP_CYCLES + TRAFFIC_N * OP_CYCLES * (1 + PAUSE_MAX));
    // queue plus port in flight, each access stretched by the longest pause.
    localparam int DRAIN_CYCLES = OP_CYCLES * (1 + PAUSE_MAX) * (lsuPkg::SLB_DEPTH + 2);

    logic                         clk;
    logic                         rst;
    logic                         rdy;
    logic                         issueEn;
    lsuPkg::memOp                 issueOp;
    logic [memBusPkg::ADDR_W-1:0] issueAddr;
    logic [memBusPkg::DATA_W-1:0] issueData;
    logic [lsuPkg::TAG_W-1:0]     issueTag;
    logic                         full;
    logic                         doneEn;
    logic [memBusPkg::DATA_W-1:0] doneData;
    logic [lsuPkg::TAG_W-1:0]     doneTag;

    logic [7:0]                   model [memBusPkg::RAM_BYTES];
    logic [lsuPkg::TAG_W-1:0]     expTag [$];
    logic [memBusPkg::DATA_W-1:0] expData [$];
    logic [lsuPkg::TAG_W-1:0]     nextTag;
    logic                         pauseOn;
    logic                         prevRdy;
    logic                         prevDone;
    int                           monErrors = 0;
    int                           seqErrors = 0;
    int                           doneCount = 0;
    int                           fullCount = 0;
    int                           pauseCycles = 0;
    int                           issueCount = 0;
    int                           passCount = 0;
    int                           failCount = 0;

    lsuTop UUT (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issueEn(issueEn), .issueOp(issueOp), .issueAddr(issueAddr),
        .issueData(issueData), .issueTag(issueTag),
        .full(full), .doneEn(doneEn), .doneData(doneData), .doneTag(doneTag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [memBusPkg::RAM_AW-1:0] byteAddr(
        logic [memBusPkg::ADDR_W-1:0] addr,
        int k
    );
        return memBusPkg::RAM_AW'(addr + 32'(k));  // the RAM wraps at 4 KiB.
    endfunction

    function automatic logic [memBusPkg::DATA_W-1:0] fillWord(logic [memBusPkg::ADDR_W-1:0] a);
        return {4'hC, a[11:0], ~a[11:0], 4'h3};
    endfunction

    function automatic logic [memBusPkg::DATA_W-1:0] expectLoad(
        lsuPkg::memOp op,
        logic [memBusPkg::ADDR_W-1:0] addr
    );
        logic [memBusPkg::DATA_W-1:0] w;
        w = {model[byteAddr(addr, 3)], model[byteAddr(addr, 2)],
             model[byteAddr(addr, 1)], model[byteAddr(addr, 0)]};
        case (op)
            lsuPkg::LB:  return {{24{w[7]}}, w[7:0]};
            lsuPkg::LH:  return {{16{w[15]}}, w[15:0]};
            lsuPkg::LBU: return {24'h0, w[7:0]};
            lsuPkg::LHU: return {16'h0, w[15:0]};
            default:     return w;
        endcase
    endfunction

    function automatic void applyStore(
        lsuPkg::memOp op,
        logic [memBusPkg::ADDR_W-1:0] addr,
        logic [memBusPkg::DATA_W-1:0] data
    );
        int len;
        len = (op == lsuPkg::SB) ? 1 : (op == lsuPkg::SH) ? 2 : 4;
        for (int k = 0; k < len; k++) begin
            model[byteAddr(addr, k)] = data[k*8 +: 8];
        end
    endfunction

    // expected results follow program order, so the model is updated at issue.
    function automatic void recordExpected(
        lsuPkg::memOp op,
        logic [memBusPkg::ADDR_W-1:0] addr,
        logic [memBusPkg::DATA_W-1:0] data,
        logic [lsuPkg::TAG_W-1:0] tag
    );
        expTag.push_back(tag);
        if (op == lsuPkg::SB || op == lsuPkg::SH || op == lsuPkg::SW) begin
            applyStore(op, addr, data);
            expData.push_back('0);
        end else begin
            expData.push_back(expectLoad(op, addr));
        end
    endfunction

    task automatic issueRequest(
        input lsuPkg::memOp op,
        input logic [memBusPkg::ADDR_W-1:0] addr,
        input logic [memBusPkg::DATA_W-1:0] data
    );
        @(negedge clk);
        while (full) begin
            @(negedge clk);
        end
        @(posedge clk);
        issueEn   <= 1'b1;
        issueOp   <= op;
        issueAddr <= addr;
        issueData <= data;
        issueTag  <= nextTag;
        @(negedge clk);
        while (!rdy) begin                     // nothing is taken in while paused.
            @(negedge clk);
        end
        recordExpected(op, addr, data, nextTag);
        nextTag = nextTag + 1'b1;
        issueCount++;
        @(posedge clk);
        issueEn <= 1'b0;
    endtask

    task automatic runTraffic(input int n);
        logic [2:0]                   opBits;
        logic [memBusPkg::ADDR_W-1:0] addr;
        for (int i = 0; i < n; i++) begin
            opBits = 3'($urandom_range(0, 7));
            addr   = 32'h100 + $urandom_range(0, 32'h7C);
            issueRequest(lsuPkg::memOp'(opBits), addr, $urandom);
        end
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (expTag.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (expTag.size() != 0) begin
            $display("%0d completions still missing after %0d cycles", expTag.size(), waited);
            seqErrors++;
            expTag.delete();
            expData.delete();
        end
    endtask

    task automatic reportTest(input int num, input string name, input int startErr);
        if (monErrors + seqErrors == startErr) begin
            passCount++;
            $display("test %0d %s: ok", num, name);
        end else begin
            failCount++;
            $display("test %0d %s: %0d errors", num, name, monErrors + seqErrors - startErr);
        end
    endtask

    // core-wide pause in random stretches while pauseOn is set.
    initial begin
        int stretch;
        rdy = 1'b1;
        forever begin
            @(posedge clk);
            if (pauseOn && ($urandom_range(0, 7) == 0)) begin
                stretch = $urandom_range(1, PAUSE_MAX);
                rdy <= 1'b0;
                repeat (stretch) @(posedge clk);
                rdy <= 1'b1;
            end
        end
    end

    // completions are checked mid-cycle; a held doneEn counts once rdy is back.
    always @(negedge clk) begin
        if (rst) begin
            prevRdy  = 1'b1;
            prevDone = 1'b0;
        end else begin
            if (!prevRdy) begin
                assert (doneEn == prevDone) else begin
                    $display("Error: doneEn %h during pause, was %h", doneEn, prevDone);
                    monErrors++;
                end
            end
            if (!rdy) pauseCycles++;
            if (full) fullCount++;
            if (doneEn && rdy) begin
                doneCount++;
                assert (expTag.size() != 0) else begin
                    $display("completion arrived with no request outstanding");
                    monErrors++;
                end
                if (expTag.size() != 0) begin
                    assert (doneTag == expTag[0]) else begin
                        $display("Error: doneTag got %h expected %h", doneTag, expTag[0]);
                        monErrors++;
                    end
                    assert (doneData == expData[0]) else begin
                        $display("Error: doneData got %h expected %h", doneData, expData[0]);
                        monErrors++;
                    end
                    void'(expTag.pop_front());
                    void'(expData.pop_front());
                end
            end
            prevRdy  = rdy;
            prevDone = doneEn;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int                           startErr;
        int                           issuedAt;
        int                           doneAt;
        int                           fullAt;
        int                           pauseAt;
        logic [memBusPkg::ADDR_W-1:0] a;

        void'($urandom(47));
        rst       = 1'b1;
        issueEn   = 1'b0;
        issueOp   = lsuPkg::LW;
        issueAddr = '0;
        issueData = '0;
        issueTag  = '0;
        nextTag   = '0;
        pauseOn   = 1'b0;
        foreach (model[i]) begin
            model[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        startErr = monErrors + seqErrors;
        @(negedge clk);
        assert (!full && !doneEn) else begin
            $display("Error: full %h doneEn %h after reset, expected 0", full, doneEn);
            seqErrors++;
        end
        a = 32'h40;
        issueRequest(lsuPkg::SW, a, $urandom);
        issueRequest(lsuPkg::LW, a, '0);
        drainResults();
        reportTest(1, "word round trip", startErr);

        startErr = monErrors + seqErrors;
        a = 32'h80;
        issueRequest(lsuPkg::SW, a, 32'h80FF7F81);
        for (int k = 0; k < 4; k++) begin
            issueRequest(lsuPkg::LB, a + 32'(k), '0);
            issueRequest(lsuPkg::LBU, a + 32'(k), '0);
        end
        for (int k = 0; k < 3; k++) begin
            issueRequest(lsuPkg::LH, a + 32'(k), '0);
            issueRequest(lsuPkg::LHU, a + 32'(k), '0);
        end
        drainResults();
        reportTest(2, "extension", startErr);

        startErr = monErrors + seqErrors;
        for (int i = 0; i < FILL_WORDS; i++) begin
            a = 32'h100 + 32'(4 * i);
            issueRequest(lsuPkg::SW, a, fillWord(a));
        end
        for (int i = 0; i < MIX_ROUNDS; i++) begin
            a = 32'h100 + $urandom_range(0, 32'h7B);
            issueRequest(lsuPkg::SB, a, $urandom);
            issueRequest(lsuPkg::SH, a + 32'h1, $urandom);
            issueRequest(lsuPkg::LW, a, '0);
        end
        drainResults();
        reportTest(3, "mixed sizes", startErr);

        startErr = monErrors + seqErrors;
        issuedAt = issueCount;
        doneAt   = doneCount;
        fullAt   = fullCount;
        runTraffic(TRAFFIC_N);
        drainResults();
        assert (fullCount != fullAt) else begin
            $display("full never went high during the traffic run");
            seqErrors++;
        end
        assert (doneCount - doneAt == issueCount - issuedAt) else begin
            $display("Error: completions %h issues %h", doneCount - doneAt, issueCount - issuedAt);
            seqErrors++;
        end
        reportTest(4, "ordering and back-pressure", startErr);

        startErr = monErrors + seqErrors;
        issuedAt = issueCount;
        doneAt   = doneCount;
        pauseAt  = pauseCycles;
        pauseOn  = 1'b1;
        runTraffic(TRAFFIC_N);
        drainResults();
        pauseOn  = 1'b0;
        assert (pauseCycles != pauseAt) else begin
            $display("rdy was never dropped during the pause run");
            seqErrors++;
        end
        assert (doneCount - doneAt == issueCount - issuedAt) else begin
            $display("Error: completions %h issues %h", doneCount - doneAt, issueCount - issuedAt);
            seqErrors++;
        end
        reportTest(5, "pause", startErr);

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && monErrors + seqErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu.f ====
common/memBusPkg.sv
common/lsuPkg.sv
slb/loadStoreBuffer.sv
dcache/dataPort.sv
src/memCtrl.sv
src/byteRam.sv
src/lsuTop.sv
bench/lsuTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module lsuTb -f lsu.f -o lsuSim > build.log 2>&1 \
    && ./obj_dir/lsuSim > sim.log 2>&1 \
    && grep -q "^TEST PASS$" sim.log \
    && echo "lsu simulation passed" \
    || { echo "lsu simulation failed, see build.log and sim.log"; exit 1; }
